/* bench/csr_tb_tasks.svh */
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

// Inputs change a little after the rising edge
task automatic next_cycle();
  @(posedge clk_i);
  #2;
endtask

task automatic read_csr(input csr_num_e addr, output logic [63:0] data);
  csr_addr_i = addr;
  csr_op_i = CSR_OP_READ;
  @(negedge clk_i);
  data = csr_rdata_o;
  next_cycle();
endtask

task automatic expect_csr(input csr_num_e addr, input logic [63:0] exp, input string name);
  logic [63:0] data;
  read_csr(addr, data);
  assert (data === exp) else value_error(name, data, exp);
endtask

// New value is visible from the following cycle
task automatic write_csr(input csr_num_e addr, input csr_op_e op, input logic [63:0] wdata);
  csr_addr_i = addr;
  csr_op_i = op;
  csr_wdata_i = wdata;
  csr_op_en_i = 1'b1;
  next_cycle();
  csr_op_en_i = 1'b0;
  csr_op_i = CSR_OP_READ;
endtask

task automatic raise_exception(input exc_cause_e cause, input logic [63:0] tval,
                               input logic [63:0] epc, output logic [63:0] tvec);
  ex_valid_i = 1'b1;
  ex_cause_i = cause;
  ex_tval_i = tval;
  ex_epc_i = epc;
  @(negedge clk_i);
  tvec = ex_tvec_o;
  next_cycle();
  ex_valid_i = 1'b0;
endtask

task automatic trap_return(input priv_lvl_e prv, output logic [63:0] epc);
  er_valid_i = 1'b1;
  er_prv_i = prv;
  @(negedge clk_i);
  epc = er_epc_o;
  next_cycle();
  er_valid_i = 1'b0;
endtask

task automatic check_access(input csr_num_e addr, input csr_op_e op, input logic illegal);
  check_addr_i = addr;
  check_op_i = op;
  @(negedge clk_i);
  assert (check_illegal_o === illegal)
    else value_error("check_illegal_o", 64'(check_illegal_o), 64'(illegal));
  next_cycle();
endtask

task automatic expect_priv(input priv_lvl_e prv);
  assert (priv_mode_o === prv) else value_error("priv_mode_o", 64'(priv_mode_o), 64'(prv));
endtask

// Cause only means something while an interrupt is pending
task automatic expect_irq(input logic pending, input logic valid, input exc_cause_e cause);
  @(negedge clk_i);
  assert (irq_pending_o === pending)
    else value_error("irq_pending_o", 64'(irq_pending_o), 64'(pending));
  assert (irq_valid_o === valid) else value_error("irq_valid_o", 64'(irq_valid_o), 64'(valid));
  if (pending) begin
    assert (irq_cause_o === cause) else value_error("irq_cause_o", 64'(irq_cause_o), 64'(cause));
  end
  next_cycle();
endtask

task automatic wait_irq_valid(input logic level, input int unsigned limit);
  int unsigned waited;
  waited = 0;
  @(negedge clk_i);
  while (irq_valid_o !== level && waited < limit) begin
    @(negedge clk_i);
    waited++;
  end
  if (irq_valid_o !== level) begin
    run_error("irq_valid_o did not reach the expected level in time");
  end
  next_cycle();
endtask

`endif

/* bench/csr_file_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module csr_file_tb;

  import csr_pkg::*;

  localparam logic [63:0] HART_ID = 64'h0000_0000_0000_0003;
  // RV64 with A, C, I, M, S and U
  localparam logic [63:0] MISA_EXP = 64'h8000_0000_0014_1105;
  localparam logic [63:0] MTVEC_VAL = 64'h0000_0000_8000_0100;
  localparam logic [63:0] STVEC_VAL = 64'h0000_0000_8000_0200;

  logic        clk_i;
  logic        rst_ni;
  logic [63:0] hart_id_i;
  csr_num_e    check_addr_i;
  csr_op_e     check_op_i;
  logic        check_illegal_o;
  csr_num_e    csr_addr_i;
  logic [63:0] csr_wdata_i;
  csr_op_e     csr_op_i;
  logic        csr_op_en_i;
  logic [63:0] csr_rdata_o;
  logic        irq_software_m_i;
  logic        irq_timer_m_i;
  logic        irq_external_m_i;
  logic        irq_external_s_i;
  logic        irq_pending_o;
  logic        irq_valid_o;
  exc_cause_e  irq_cause_o;
  logic        ex_valid_i;
  exc_cause_e  ex_cause_i;
  logic [63:0] ex_tval_i;
  logic [63:0] ex_epc_i;
  logic [63:0] ex_tvec_o;
  logic        er_valid_i;
  priv_lvl_e   er_prv_i;
  logic [63:0] er_epc_o;
  logic        instr_ret_i;
  priv_lvl_e   priv_mode_o;
  logic [31:0] rng_state;

  csr_file DUT (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [63:0] random_word();
    logic [31:0] hi;
    rng_state = xorshift32(rng_state);
    hi = rng_state;
    rng_state = xorshift32(rng_state);
    return {hi, rng_state};
  endfunction

  task automatic stop_run();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
    stop_run();
  endtask

  task automatic run_error(input string what);
    $display("Error at %0t: %s", $time, what);
    stop_run();
  endtask

  `include "csr_tb_tasks.svh"

  initial begin
    logic [63:0] data;
    logic [63:0] first;
    logic [63:0] second;
    logic [63:0] wdata;
    logic [63:0] tval;
    logic [63:0] epc;
    logic [63:0] vec;
    logic [63:0] scratch [2];
    csr_num_e    addr;
    csr_op_e     op;
    int unsigned idx;
    int unsigned pulses;

    clk_i = 1'b0;
    rst_ni = 1'b0;
    hart_id_i = HART_ID;
    check_addr_i = CSR_MSTATUS;
    check_op_i = CSR_OP_READ;
    csr_addr_i = CSR_MSTATUS;
    csr_wdata_i = '0;
    csr_op_i = CSR_OP_READ;
    csr_op_en_i = 1'b0;
    irq_software_m_i = 1'b0;
    irq_timer_m_i = 1'b0;
    irq_external_m_i = 1'b0;
    irq_external_s_i = 1'b0;
    ex_valid_i = 1'b0;
    ex_cause_i = EXC_CAUSE_INSN_ADDR_MISA;
    ex_tval_i = '0;
    ex_epc_i = '0;
    er_valid_i = 1'b0;
    er_prv_i = PRIV_LVL_M;
    instr_ret_i = 1'b0;
    rng_state = 32'h1ee2;
    scratch[0] = '0;
    scratch[1] = '0;
    repeat (16) @(posedge clk_i);
    #2 rst_ni = 1'b1;

    //////////////////////////////////////////////////
    // Reset state and counters
    expect_priv(PRIV_LVL_M);
    expect_irq(1'b0, 1'b0, EXC_CAUSE_IRQ_TIMER_S);
    expect_csr(CSR_MSTATUS, 64'h0, "mstatus");
    // Second sample lands ten cycles after the first
    read_csr(CSR_MCYCLE, first);
    repeat (9) next_cycle();
    read_csr(CSR_MCYCLE, second);
    assert (second - first === 64'd10) else value_error("mcycle delta", second - first, 64'd10);
    read_csr(CSR_MINSTRET, first);
    pulses = 0;
    repeat (24) begin
      data = random_word();
      instr_ret_i = data[0];
      pulses += instr_ret_i;
      next_cycle();
    end
    instr_ret_i = 1'b0;
    read_csr(CSR_MINSTRET, second);
    assert (second - first === 64'(pulses))
      else value_error("minstret delta", second - first, 64'(pulses));
    data = random_word();
    write_csr(CSR_MCYCLE, CSR_OP_WRITE, data);
    expect_csr(CSR_MCYCLE, data, "mcycle");

    //////////////////////////////////////////////////
    // CSR operations on both scratch registers
    for (int i = 0; i < 16; i++) begin
      idx = i % 2;
      addr = idx ? CSR_SSCRATCH : CSR_MSCRATCH;
      // Write, set and clear in turn on each register
      op = csr_op_e'(1 + (i / 2) % 3);
      wdata = random_word();
      case (op)
        CSR_OP_SET:   scratch[idx] = scratch[idx] | wdata;
        CSR_OP_CLEAR: scratch[idx] = scratch[idx] & ~wdata;
        default:      scratch[idx] = wdata;
      endcase
      write_csr(addr, op, wdata);
      expect_csr(addr, scratch[idx], "scratch");
    end
    write_csr(CSR_MEPC, CSR_OP_WRITE, 64'h8000_0000_0000_1235);
    expect_csr(CSR_MEPC, 64'h8000_0000_0000_1234, "mepc");
    expect_csr(CSR_MISA, MISA_EXP, "misa");
    expect_csr(CSR_MHARTID, HART_ID, "mhartid");

    // M-mode trap and return
    write_csr(CSR_MTVEC, CSR_OP_WRITE, MTVEC_VAL);
    write_csr(CSR_MSTATUS, CSR_OP_WRITE, 64'h8);
    tval = random_word();
    epc = random_word() & ~64'h1;
    raise_exception(EXC_CAUSE_ILLEGAL_INSN, tval, epc, vec);
    assert (vec === MTVEC_VAL) else value_error("ex_tvec_o", vec, MTVEC_VAL);
    expect_priv(PRIV_LVL_M);
    expect_csr(CSR_MEPC, epc, "mepc");
    expect_csr(CSR_MCAUSE, 64'h2, "mcause");
    expect_csr(CSR_MTVAL, tval, "mtval");
    // MPIE holds the old MIE, MPP holds M
    expect_csr(CSR_MSTATUS, 64'h1880, "mstatus");
    trap_return(PRIV_LVL_M, vec);
    assert (vec === epc) else value_error("er_epc_o", vec, epc);
    expect_priv(PRIV_LVL_M);
    expect_csr(CSR_MSTATUS, 64'h88, "mstatus");

    //////////////////////////////////////////////////
    // Delegation of the U-mode ecall
    write_csr(CSR_MEDELEG, CSR_OP_WRITE, 64'h100);
    write_csr(CSR_STVEC, CSR_OP_WRITE, STVEC_VAL);
    write_csr(CSR_MSTATUS, CSR_OP_WRITE, 64'h0);
    trap_return(PRIV_LVL_M, vec);
    expect_priv(PRIV_LVL_U);
    epc = random_word() & ~64'h1;
    raise_exception(EXC_CAUSE_ECALL_UMODE, tval, epc, vec);
    assert (vec === STVEC_VAL) else value_error("ex_tvec_o", vec, STVEC_VAL);
    expect_priv(PRIV_LVL_S);
    expect_csr(CSR_SCAUSE, 64'h8, "scause");
    expect_csr(CSR_SEPC, epc, "sepc");
    raise_exception(EXC_CAUSE_BREAKPOINT, tval, epc, vec);
    assert (vec === MTVEC_VAL) else value_error("ex_tvec_o", vec, MTVEC_VAL);
    expect_priv(PRIV_LVL_M);
    expect_csr(CSR_MCAUSE, 64'h3, "mcause");

    // Interrupts
    write_csr(CSR_MIE, CSR_OP_WRITE, 64'h80);
    write_csr(CSR_MSTATUS, CSR_OP_SET, 64'h8);
    irq_timer_m_i = 1'b1;
    wait_irq_valid(1'b1, 4);
    expect_irq(1'b1, 1'b1, EXC_CAUSE_IRQ_TIMER_M);
    irq_external_m_i = 1'b1;
    write_csr(CSR_MIE, CSR_OP_SET, 64'h800);
    expect_irq(1'b1, 1'b1, EXC_CAUSE_IRQ_EXTERNAL_M);
    write_csr(CSR_MSTATUS, CSR_OP_CLEAR, 64'h8);
    expect_irq(1'b1, 1'b0, EXC_CAUSE_IRQ_EXTERNAL_M);
    irq_timer_m_i = 1'b0;
    irq_external_m_i = 1'b0;
    write_csr(CSR_MIE, CSR_OP_WRITE, 64'h2);
    write_csr(CSR_MIDELEG, CSR_OP_WRITE, 64'h2);
    write_csr(CSR_MIP, CSR_OP_WRITE, 64'h2);
    // Delegated interrupt stays masked while in M
    expect_irq(1'b1, 1'b0, EXC_CAUSE_IRQ_SOFTWARE_S);
    write_csr(CSR_MSTATUS, CSR_OP_CLEAR, 64'h1800);
    trap_return(PRIV_LVL_M, vec);
    expect_priv(PRIV_LVL_U);
    expect_irq(1'b1, 1'b1, EXC_CAUSE_IRQ_SOFTWARE_S);

    //////////////////////////////////////////////////
    // Access check, starting from U
    check_access(csr_num_e'(12'hC03), CSR_OP_READ, 1'b1);
    check_access(CSR_CYCLE, CSR_OP_READ, 1'b1);
    write_csr(CSR_MCOUNTEREN, CSR_OP_WRITE, 64'h1);
    check_access(CSR_CYCLE, CSR_OP_READ, 1'b1);
    write_csr(CSR_SCOUNTEREN, CSR_OP_WRITE, 64'h1);
    check_access(CSR_CYCLE, CSR_OP_READ, 1'b0);
    raise_exception(EXC_CAUSE_ECALL_UMODE, tval, epc, vec);
    expect_priv(PRIV_LVL_S);
    check_access(CSR_MSTATUS, CSR_OP_READ, 1'b1);
    check_access(CSR_SSTATUS, CSR_OP_READ, 1'b0);
    raise_exception(EXC_CAUSE_ILLEGAL_INSN, tval, epc, vec);
    expect_priv(PRIV_LVL_M);
    check_access(CSR_MHARTID, CSR_OP_READ, 1'b0);
    check_access(CSR_MHARTID, CSR_OP_WRITE, 1'b1);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+bench
src/csr_pkg.sv
src/csr_access_check.sv
src/irq_ctrl.sv
src/trap_ctrl.sv
src/perf_counters.sv
src/csr_file.sv
bench/csr_file_tb.sv

/* src/csr_access_check.sv */
`default_nettype none
`timescale 1ns/100ps

module csr_access_check (
  input  csr_pkg::csr_num_e  check_addr_i,
  input  csr_pkg::csr_op_e   check_op_i,
  input  csr_pkg::priv_lvl_e priv_lvl_i,
  input  logic [2:0]         mcounteren_i,
  input  logic [2:0]         scounteren_i,
  output logic               check_illegal_o
);

  import csr_pkg::*;

  logic illegal_addr;
  logic illegal_readonly;
  logic illegal_prv;

  // Top two address bits set means read only
  assign illegal_readonly = (check_addr_i[11:10] == 2'b11) && (check_op_i != CSR_OP_READ);
  assign illegal_prv = check_addr_i[9:8] > priv_lvl_i;

  always_comb begin
    illegal_addr = 1'b0;
    case (check_addr_i)
      // Below M the counter needs mcounteren, in U also scounteren
      CSR_CYCLE:
        illegal_addr = !((priv_lvl_i > PRIV_LVL_S || mcounteren_i[0]) &&
                         (priv_lvl_i > PRIV_LVL_U || scounteren_i[0]));
      CSR_INSTRET:
        illegal_addr = !((priv_lvl_i > PRIV_LVL_S || mcounteren_i[2]) &&
                         (priv_lvl_i > PRIV_LVL_U || scounteren_i[2]));
      CSR_SSTATUS, CSR_SIE, CSR_STVEC, CSR_SCOUNTEREN, CSR_SSCRATCH,
      CSR_SEPC, CSR_SCAUSE, CSR_STVAL, CSR_SIP:;
      CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID:;
      CSR_MSTATUS, CSR_MISA, CSR_MEDELEG, CSR_MIDELEG, CSR_MIE, CSR_MTVEC,
      CSR_MCOUNTEREN, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP:;
      CSR_MCYCLE, CSR_MINSTRET:;
      default: illegal_addr = 1'b1;
    endcase
  end

  assign check_illegal_o = illegal_addr | illegal_readonly | illegal_prv;

endmodule

`default_nettype wire

/* src/csr_file.sv */
`default_nettype none
`timescale 1ns/100ps

module csr_file (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [63:0]          hart_id_i,
  // ID stage access check
  input  csr_pkg::csr_num_e    check_addr_i,
  input  csr_pkg::csr_op_e     check_op_i,
  output logic                 check_illegal_o,
  // CSR access port
  input  csr_pkg::csr_num_e    csr_addr_i,
  input  logic [63:0]          csr_wdata_i,
  input  csr_pkg::csr_op_e     csr_op_i,
  input  logic                 csr_op_en_i,
  output logic [63:0]          csr_rdata_o,
  // Interrupts
  input  logic                 irq_software_m_i,
  input  logic                 irq_timer_m_i,
  input  logic                 irq_external_m_i,
  input  logic                 irq_external_s_i,
  output logic                 irq_pending_o,
  output logic                 irq_valid_o,
  output csr_pkg::exc_cause_e  irq_cause_o,
  // Exception entry and return
  input  logic                 ex_valid_i,
  input  csr_pkg::exc_cause_e  ex_cause_i,
  input  logic [63:0]          ex_tval_i,
  input  logic [63:0]          ex_epc_i,
  output logic [63:0]          ex_tvec_o,
  input  logic                 er_valid_i,
  input  csr_pkg::priv_lvl_e   er_prv_i,
  output logic [63:0]          er_epc_o,
  input  logic                 instr_ret_i,
  output csr_pkg::priv_lvl_e   priv_mode_o
);

  import csr_pkg::*;

  priv_lvl_e   priv_lvl;
  logic        mstatus_mie;
  logic        mstatus_sie;
  logic [2:0]  mideleg_s;
  logic [2:0]  mcounteren;
  logic [2:0]  scounteren;
  logic [63:0] rdata_trap;
  logic [63:0] rdata_irq;
  logic [63:0] rdata_perf;
  logic        csr_we;

  // Trap entry and return win over a CSR op
  assign csr_we = csr_op_en_i & ~ex_valid_i & ~er_valid_i;

  // Unowned addresses read as zero in each block
  assign csr_rdata_o = rdata_trap | rdata_irq | rdata_perf;
  assign priv_mode_o = priv_lvl;

  csr_access_check u_access_check (
    .check_addr_i    (check_addr_i),
    .check_op_i      (check_op_i),
    .priv_lvl_i      (priv_lvl),
    .mcounteren_i    (mcounteren),
    .scounteren_i    (scounteren),
    .check_illegal_o (check_illegal_o)
  );

  irq_ctrl u_irq_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .csr_addr_i       (csr_addr_i),
    .csr_wdata_i      (csr_wdata_i),
    .csr_op_i         (csr_op_i),
    .csr_we_i         (csr_we),
    .irq_software_m_i (irq_software_m_i),
    .irq_timer_m_i    (irq_timer_m_i),
    .irq_external_m_i (irq_external_m_i),
    .irq_external_s_i (irq_external_s_i),
    .priv_lvl_i       (priv_lvl),
    .mstatus_mie_i    (mstatus_mie),
    .mstatus_sie_i    (mstatus_sie),
    .mideleg_s_o      (mideleg_s),
    .rdata_o          (rdata_irq),
    .irq_pending_o    (irq_pending_o),
    .irq_valid_o      (irq_valid_o),
    .irq_cause_o      (irq_cause_o)
  );

  trap_ctrl u_trap_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .hart_id_i     (hart_id_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_op_i      (csr_op_i),
    .csr_op_en_i   (csr_we),
    .ex_valid_i    (ex_valid_i),
    .ex_cause_i    (ex_cause_i),
    .ex_tval_i     (ex_tval_i),
    .ex_epc_i      (ex_epc_i),
    .ex_tvec_o     (ex_tvec_o),
    .er_valid_i    (er_valid_i),
    .er_prv_i      (er_prv_i),
    .er_epc_o      (er_epc_o),
    .mideleg_s_i   (mideleg_s),
    .priv_lvl_o    (priv_lvl),
    .mstatus_mie_o (mstatus_mie),
    .mstatus_sie_o (mstatus_sie),
    .rdata_o       (rdata_trap)
  );

  perf_counters u_perf_counters (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_op_i     (csr_op_i),
    .csr_we_i     (csr_we),
    .instr_ret_i  (instr_ret_i),
    .mcounteren_o (mcounteren),
    .scounteren_o (scounteren),
    .rdata_o      (rdata_perf)
  );

endmodule

`default_nettype wire

/* src/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  //////////////////////////////////////////////////
  // Encodings

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // Top bit marks an interrupt, low bits hold the code
  typedef enum logic [4:0] {
    EXC_CAUSE_INSN_ADDR_MISA     = 5'h00, EXC_CAUSE_INSTR_ACCESS_FAULT = 5'h01,
    EXC_CAUSE_ILLEGAL_INSN       = 5'h02, EXC_CAUSE_BREAKPOINT         = 5'h03,
    EXC_CAUSE_LOAD_MISALIGN      = 5'h04, EXC_CAUSE_LOAD_ACCESS_FAULT  = 5'h05,
    EXC_CAUSE_STORE_MISALIGN     = 5'h06, EXC_CAUSE_STORE_ACCESS_FAULT = 5'h07,
    EXC_CAUSE_ECALL_UMODE        = 5'h08, EXC_CAUSE_ECALL_SMODE        = 5'h09,
    EXC_CAUSE_INSTR_PAGE_FAULT   = 5'h0C, EXC_CAUSE_LOAD_PAGE_FAULT    = 5'h0D,
    EXC_CAUSE_STORE_PAGE_FAULT   = 5'h0F,
    EXC_CAUSE_IRQ_SOFTWARE_S     = 5'h11, EXC_CAUSE_IRQ_SOFTWARE_M     = 5'h13,
    EXC_CAUSE_IRQ_TIMER_S        = 5'h15, EXC_CAUSE_IRQ_TIMER_M        = 5'h17,
    EXC_CAUSE_IRQ_EXTERNAL_S     = 5'h19, EXC_CAUSE_IRQ_EXTERNAL_M     = 5'h1B
  } exc_cause_e;

  typedef enum logic [11:0] {
    CSR_CYCLE     = 12'hC00, CSR_INSTRET    = 12'hC02,
    CSR_SSTATUS   = 12'h100, CSR_SIE        = 12'h104, CSR_STVEC    = 12'h105,
    CSR_SCOUNTEREN = 12'h106,
    CSR_SSCRATCH  = 12'h140, CSR_SEPC       = 12'h141, CSR_SCAUSE   = 12'h142,
    CSR_STVAL     = 12'h143, CSR_SIP        = 12'h144,
    CSR_MVENDORID = 12'hF11, CSR_MARCHID    = 12'hF12, CSR_MIMPID   = 12'hF13,
    CSR_MHARTID   = 12'hF14,
    CSR_MSTATUS   = 12'h300, CSR_MISA       = 12'h301, CSR_MEDELEG  = 12'h302,
    CSR_MIDELEG   = 12'h303, CSR_MIE        = 12'h304, CSR_MTVEC    = 12'h305,
    CSR_MCOUNTEREN = 12'h306,
    CSR_MSCRATCH  = 12'h340, CSR_MEPC       = 12'h341, CSR_MCAUSE   = 12'h342,
    CSR_MTVAL     = 12'h343, CSR_MIP        = 12'h344,
    CSR_MCYCLE    = 12'hB00, CSR_MINSTRET   = 12'hB02
  } csr_num_e;

  // Standard mstatus layout, unused fields kept as zero
  typedef struct packed {
    logic [50:0] wpri_hi;
    priv_lvl_e   mpp;
    logic [1:0]  wpri_10_9;
    logic        spp;
    logic        mpie;
    logic        wpri_6;
    logic        spie;
    logic        wpri_4;
    logic        mie;
    logic        wpri_2;
    logic        sie;
    logic        wpri_0;
  } mstatus_bits_t;

  typedef union packed {
    logic [63:0]   raw;
    mstatus_bits_t st;
  } csr_word_u;

  //////////////////////////////////////////////////
  // Constants

  localparam int unsigned SSIX_BIT = 1;
  localparam int unsigned MSIX_BIT = 3;
  localparam int unsigned STIX_BIT = 5;
  localparam int unsigned MTIX_BIT = 7;
  localparam int unsigned SEIX_BIT = 9;
  localparam int unsigned MEIX_BIT = 11;

  localparam logic [11:0] S_IRQ_MASK = 12'((1 << SSIX_BIT) | (1 << STIX_BIT) | (1 << SEIX_BIT));
  localparam logic [11:0] IRQ_MASK = S_IRQ_MASK |
      12'((1 << MSIX_BIT) | (1 << MTIX_BIT) | (1 << MEIX_BIT));

  // SIE, SPIE and SPP
  localparam logic [63:0] SSTATUS_MASK = 64'h0000_0000_0000_0122;

  // MXL of 2 for RV64, then U, S, M, I, C and A
  localparam logic [63:0] MISA_VALUE = (64'd2 << 62) | (64'd1 << 20) | (64'd1 << 18) |
      (64'd1 << 12) | (64'd1 << 8) | (64'd1 << 2) | 64'd1;

  // Only the cycle and instret enables exist
  localparam logic [2:0] COUNTEREN_MASK = 3'b101;

  // Causes 10, 11 and 14 cannot be delegated
  localparam logic [15:0] MEDELEG_MASK = 16'hB3FF;

  function automatic logic [63:0] apply_csr_op(input csr_op_e op, input logic [63:0] old_val,
                                               input logic [63:0] wdata);
    logic [63:0] result;
    case (op)
      CSR_OP_WRITE: result = wdata;
      CSR_OP_SET:   result = old_val | wdata;
      CSR_OP_CLEAR: result = old_val & ~wdata;
      default:      result = old_val;
    endcase
    return result;
  endfunction

endpackage

`default_nettype wire

/* src/irq_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

module irq_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  csr_pkg::csr_num_e   csr_addr_i,
  input  logic [63:0]         csr_wdata_i,
  input  csr_pkg::csr_op_e    csr_op_i,
  input  logic                csr_we_i,
  input  logic                irq_software_m_i,
  input  logic                irq_timer_m_i,
  input  logic                irq_external_m_i,
  input  logic                irq_external_s_i,
  input  csr_pkg::priv_lvl_e  priv_lvl_i,
  input  logic                mstatus_mie_i,
  input  logic                mstatus_sie_i,
  output logic [2:0]          mideleg_s_o,
  output logic [63:0]         rdata_o,
  output logic                irq_pending_o,
  output logic                irq_valid_o,
  output csr_pkg::exc_cause_e irq_cause_o
);

  import csr_pkg::*;

  logic        ssip_q;
  logic        stip_q;
  logic        seip_q;
  logic [11:0] mie_q;
  logic [11:0] mideleg_q;
  logic [11:0] mip_sw;
  logic [11:0] mip;
  logic [11:0] old_val;
  logic [11:0] rd_val;
  logic [63:0] wval;
  logic [11:0] irq_pending;
  logic [11:0] irq_valid_m;
  logic [11:0] irq_valid_s;

  // Register view of mip, the external S line joins only on reads
  always_comb begin
    mip_sw = '0;
    mip_sw[SSIX_BIT] = ssip_q;
    mip_sw[MSIX_BIT] = irq_software_m_i;
    mip_sw[STIX_BIT] = stip_q;
    mip_sw[MTIX_BIT] = irq_timer_m_i;
    mip_sw[SEIX_BIT] = seip_q;
    mip_sw[MEIX_BIT] = irq_external_m_i;
    mip = mip_sw;
    mip[SEIX_BIT] = seip_q | irq_external_s_i;
  end

  always_comb begin
    case (csr_addr_i)
      CSR_SIE:     old_val = mie_q & mideleg_q;
      CSR_SIP:     old_val = mip_sw & mideleg_q;
      CSR_MIE:     old_val = mie_q;
      CSR_MIP:     old_val = mip_sw;
      CSR_MIDELEG: old_val = mideleg_q;
      default:     old_val = '0;
    endcase
    rd_val = old_val;
    if (csr_addr_i == CSR_MIP || (csr_addr_i == CSR_SIP && mideleg_q[SEIX_BIT])) begin
      rd_val[SEIX_BIT] = mip[SEIX_BIT];
    end
  end

  assign rdata_o = {52'b0, rd_val};
  assign wval = apply_csr_op(csr_op_i, {52'b0, old_val}, csr_wdata_i);
  assign mideleg_s_o = {mideleg_q[SEIX_BIT], mideleg_q[STIX_BIT], mideleg_q[SSIX_BIT]};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ssip_q    <= 1'b0;
      stip_q    <= 1'b0;
      seip_q    <= 1'b0;
      mie_q     <= '0;
      mideleg_q <= '0;
    end else if (csr_we_i && csr_op_i != CSR_OP_READ) begin
      case (csr_addr_i)
        // S view reaches delegated enables only
        CSR_SIE:     mie_q <= (mie_q & ~mideleg_q) | (wval[11:0] & mideleg_q);
        CSR_SIP:     if (mideleg_q[SSIX_BIT]) ssip_q <= wval[SSIX_BIT];
        CSR_MIE:     mie_q <= wval[11:0] & IRQ_MASK;
        CSR_MIDELEG: mideleg_q <= wval[11:0] & S_IRQ_MASK;
        CSR_MIP: begin
          ssip_q <= wval[SSIX_BIT];
          stip_q <= wval[STIX_BIT];
          seip_q <= wval[SEIX_BIT];
        end
        default:;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Pending, valid and cause

  assign irq_pending = mip & mie_q;
  assign irq_valid_m = (priv_lvl_i != PRIV_LVL_M || mstatus_mie_i) ?
                       (irq_pending & ~mideleg_q) : '0;
  assign irq_valid_s = (priv_lvl_i == PRIV_LVL_U || (priv_lvl_i == PRIV_LVL_S && mstatus_sie_i)) ?
                       (irq_pending & mideleg_q) : '0;
  assign irq_pending_o = |irq_pending;
  assign irq_valid_o = |(irq_valid_m | irq_valid_s);

  always_comb begin
    if (irq_pending[MEIX_BIT]) irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    else if (irq_pending[MSIX_BIT]) irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    else if (irq_pending[MTIX_BIT]) irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    else if (irq_pending[SEIX_BIT]) irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_S;
    else if (irq_pending[SSIX_BIT]) irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_S;
    else irq_cause_o = EXC_CAUSE_IRQ_TIMER_S;
  end

endmodule

`default_nettype wire

/* src/perf_counters.sv */
`default_nettype none
`timescale 1ns/100ps

module perf_counters (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  csr_pkg::csr_num_e csr_addr_i,
  input  logic [63:0]       csr_wdata_i,
  input  csr_pkg::csr_op_e  csr_op_i,
  input  logic              csr_we_i,
  input  logic              instr_ret_i,
  output logic [2:0]        mcounteren_o,
  output logic [2:0]        scounteren_o,
  output logic [63:0]       rdata_o
);

  import csr_pkg::*;

  logic [63:0] mcycle_q;
  logic [63:0] minstret_q;
  logic [63:0] wval;

  always_comb begin
    case (csr_addr_i)
      CSR_MCYCLE, CSR_CYCLE:     rdata_o = mcycle_q;
      CSR_MINSTRET, CSR_INSTRET: rdata_o = minstret_q;
      CSR_MCOUNTEREN:            rdata_o = {61'b0, mcounteren_o};
      CSR_SCOUNTEREN:            rdata_o = {61'b0, scounteren_o};
      default:                   rdata_o = '0;
    endcase
  end

  assign wval = apply_csr_op(csr_op_i, rdata_o, csr_wdata_i);

  // Later assignments win, so a write replaces the increment
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcycle_q     <= '0;
      minstret_q   <= '0;
      mcounteren_o <= '0;
      scounteren_o <= '0;
    end else begin
      mcycle_q <= mcycle_q + 64'd1;
      if (instr_ret_i) minstret_q <= minstret_q + 64'd1;
      if (csr_we_i && csr_op_i != CSR_OP_READ) begin
        case (csr_addr_i)
          CSR_MCYCLE:     mcycle_q <= wval;
          CSR_MINSTRET:   minstret_q <= wval;
          CSR_MCOUNTEREN: mcounteren_o <= wval[2:0] & COUNTEREN_MASK;
          CSR_SCOUNTEREN: scounteren_o <= wval[2:0] & COUNTEREN_MASK;
          default:;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* src/trap_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

module trap_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [63:0]         hart_id_i,
  input  csr_pkg::csr_num_e   csr_addr_i,
  input  logic [63:0]         csr_wdata_i,
  input  csr_pkg::csr_op_e    csr_op_i,
  input  logic                csr_op_en_i,
  input  logic                ex_valid_i,
  input  csr_pkg::exc_cause_e ex_cause_i,
  input  logic [63:0]         ex_tval_i,
  input  logic [63:0]         ex_epc_i,
  output logic [63:0]         ex_tvec_o,
  input  logic                er_valid_i,
  input  csr_pkg::priv_lvl_e  er_prv_i,
  output logic [63:0]         er_epc_o,
  input  logic [2:0]          mideleg_s_i,
  output csr_pkg::priv_lvl_e  priv_lvl_o,
  output logic                mstatus_mie_o,
  output logic                mstatus_sie_o,
  output logic [63:0]         rdata_o
);

  import csr_pkg::*;

  priv_lvl_e     priv_q;
  mstatus_bits_t mstatus_q;
  logic [15:0]   medeleg_q;
  logic [63:0]   mscratch_q, mepc_q, mtval_q, mtvec_q;
  logic [63:0]   sscratch_q, sepc_q, stval_q, stvec_q;
  exc_cause_e    mcause_q, scause_q;
  csr_word_u     rd_w;
  csr_word_u     wr_w;
  logic          cause_deleg;
  logic          ex_deleg;

  assign priv_lvl_o    = priv_q;
  assign mstatus_mie_o = mstatus_q.mie;
  assign mstatus_sie_o = mstatus_q.sie;

  // Interrupt causes follow mideleg, exceptions follow medeleg
  always_comb begin
    case (ex_cause_i)
      EXC_CAUSE_IRQ_SOFTWARE_S: cause_deleg = mideleg_s_i[0];
      EXC_CAUSE_IRQ_TIMER_S:    cause_deleg = mideleg_s_i[1];
      EXC_CAUSE_IRQ_EXTERNAL_S: cause_deleg = mideleg_s_i[2];
      default: cause_deleg = !ex_cause_i[4] && medeleg_q[ex_cause_i[3:0]];
    endcase
  end

  assign ex_deleg  = (priv_q != PRIV_LVL_M) && cause_deleg;
  assign ex_tvec_o = ex_deleg ? stvec_q : mtvec_q;
  assign er_epc_o  = (er_prv_i == PRIV_LVL_M) ? mepc_q : sepc_q;

  always_comb begin
    rd_w.raw = '0;
    case (csr_addr_i)
      CSR_SSTATUS:  rd_w.raw = mstatus_q & SSTATUS_MASK;
      CSR_STVEC:    rd_w.raw = stvec_q;
      CSR_SSCRATCH: rd_w.raw = sscratch_q;
      CSR_SEPC:     rd_w.raw = sepc_q;
      CSR_SCAUSE:   rd_w.raw = {scause_q[4], 59'b0, scause_q[3:0]};
      CSR_STVAL:    rd_w.raw = stval_q;
      CSR_MSTATUS:  rd_w.st  = mstatus_q;
      CSR_MISA:     rd_w.raw = MISA_VALUE;
      CSR_MEDELEG:  rd_w.raw = {48'b0, medeleg_q};
      CSR_MTVEC:    rd_w.raw = mtvec_q;
      CSR_MSCRATCH: rd_w.raw = mscratch_q;
      CSR_MEPC:     rd_w.raw = mepc_q;
      CSR_MCAUSE:   rd_w.raw = {mcause_q[4], 59'b0, mcause_q[3:0]};
      CSR_MTVAL:    rd_w.raw = mtval_q;
      CSR_MHARTID:  rd_w.raw = hart_id_i;
      // No vendor, architecture or implementation ID
      CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID: rd_w.raw = '0;
      default:;
    endcase
    wr_w.raw = apply_csr_op(csr_op_i, rd_w.raw, csr_wdata_i);
  end

  assign rdata_o = rd_w.raw;

  //////////////////////////////////////////////////
  // Trap entry, return and CSR writes

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      priv_q     <= PRIV_LVL_M;
      mstatus_q  <= '0;
      medeleg_q  <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= EXC_CAUSE_INSN_ADDR_MISA;
      mtval_q    <= '0;
      mtvec_q    <= '0;
      sscratch_q <= '0;
      sepc_q     <= '0;
      scause_q   <= EXC_CAUSE_INSN_ADDR_MISA;
      stval_q    <= '0;
      stvec_q    <= '0;
    end else if (ex_valid_i) begin
      if (ex_deleg) begin
        priv_q         <= PRIV_LVL_S;
        mstatus_q.spie <= mstatus_q.sie;
        mstatus_q.sie  <= 1'b0;
        mstatus_q.spp  <= priv_q[0];
        sepc_q         <= ex_epc_i;
        scause_q       <= ex_cause_i;
        stval_q        <= ex_tval_i;
      end else begin
        priv_q         <= PRIV_LVL_M;
        mstatus_q.mpie <= mstatus_q.mie;
        mstatus_q.mie  <= 1'b0;
        mstatus_q.mpp  <= priv_q;
        mepc_q         <= ex_epc_i;
        mcause_q       <= ex_cause_i;
        mtval_q        <= ex_tval_i;
      end
    end else if (er_valid_i) begin
      if (er_prv_i == PRIV_LVL_M) begin
        priv_q         <= mstatus_q.mpp;
        mstatus_q.mie  <= mstatus_q.mpie;
        mstatus_q.mpie <= 1'b1;
        mstatus_q.mpp  <= PRIV_LVL_U;
      end else begin
        priv_q         <= mstatus_q.spp ? PRIV_LVL_S : PRIV_LVL_U;
        mstatus_q.sie  <= mstatus_q.spie;
        mstatus_q.spie <= 1'b1;
        mstatus_q.spp  <= 1'b0;
      end
    end else if (csr_op_en_i && csr_op_i != CSR_OP_READ) begin
      case (csr_addr_i)
        CSR_MSTATUS: begin
          mstatus_q.mie  <= wr_w.st.mie;
          mstatus_q.mpie <= wr_w.st.mpie;
          // Reserved level 2 maps to M
          mstatus_q.mpp  <= (wr_w.st.mpp == priv_lvl_e'(2'b10)) ? PRIV_LVL_M : wr_w.st.mpp;
          mstatus_q.sie  <= wr_w.st.sie;
          mstatus_q.spie <= wr_w.st.spie;
          mstatus_q.spp  <= wr_w.st.spp;
        end
        CSR_SSTATUS: begin
          mstatus_q.sie  <= wr_w.st.sie;
          mstatus_q.spie <= wr_w.st.spie;
          mstatus_q.spp  <= wr_w.st.spp;
        end
        CSR_MEDELEG:  medeleg_q <= wr_w.raw[15:0] & MEDELEG_MASK;
        CSR_MTVEC:    mtvec_q <= {wr_w.raw[63:2], 2'b00};
        CSR_MSCRATCH: mscratch_q <= wr_w.raw;
        CSR_MEPC:     mepc_q <= {wr_w.raw[63:1], 1'b0};
        CSR_MCAUSE:   mcause_q <= exc_cause_e'({wr_w.raw[63], wr_w.raw[3:0]});
        CSR_MTVAL:    mtval_q <= wr_w.raw;
        CSR_STVEC:    stvec_q <= {wr_w.raw[63:2], 2'b00};
        CSR_SSCRATCH: sscratch_q <= wr_w.raw;
        CSR_SEPC:     sepc_q <= {wr_w.raw[63:1], 1'b0};
        CSR_SCAUSE:   scause_q <= exc_cause_e'({wr_w.raw[63], wr_w.raw[3:0]});
        CSR_STVAL:    stval_q <= wr_w.raw;
        default:;
      endcase
    end
  end

endmodule

`default_nettype wire
